/* rtl/icache_cfg_pkg.sv */
/*
 * cache geometry and the address, data and way types shared by the icache RTL
 * and its testbench, referenced by scoped name
 */
package icache_cfg_pkg;

  localparam int ways_c        = 4;
  localparam int sets_c        = 64;
  localparam int paddr_width_c = 32;
  localparam int instr_width_c = 32;
  localparam int block_width_c = 128;

  // fetch address fields: tag | index | word | byte
  localparam int word_lsb_c     = 2;
  localparam int word_width_c   = 2;
  localparam int index_lsb_c    = 4;
  localparam int index_width_c  = 6;
  localparam int tag_lsb_c      = 10;
  localparam int tag_width_c    = 22;

  typedef logic [paddr_width_c-1:0] paddr_t;
  typedef logic [tag_width_c-1:0]   ptag_t;
  typedef logic [index_width_c-1:0] index_t;
  typedef logic [word_width_c-1:0]  word_sel_t;
  typedef logic [1:0]               way_t;
  typedef logic [ways_c-1:0]        way_vec_t;
  typedef logic [instr_width_c-1:0] instr_t;
  // word 0 in the low bits
  typedef logic [block_width_c-1:0] block_t;

endpackage

/* rtl/icache_msg_pkg.sv */
/*
 * miss tracker states and the per-set pseudo-LRU tree encoding
 */
package icache_msg_pkg;

  typedef enum logic [1:0] {
    e_ready,
    e_send_req,
    e_wait_fill
  } miss_state_e;

  // tree bits, each pointing at the less recently used side
  //   bit 0: half select, 0 means ways 0/1
  //   bit 1: way 0 vs way 1
  //   bit 2: way 2 vs way 3
  typedef logic [2:0] lru_bits_t;

endpackage

/* rtl/icache_fill_if.sv */
/*
 * fill write from the miss controller to the tag array, data array and LRU,
 * a single-cycle strobe with no handshake
 */
`timescale 1ns/10ps

interface icache_fill_if;

  logic                   valid;
  icache_cfg_pkg::index_t index;
  icache_cfg_pkg::way_t   way;
  icache_cfg_pkg::ptag_t  tag;
  icache_cfg_pkg::block_t data;

  modport miss_ctrl (
    output valid, index, way, tag, data
  );

  // shared by tag array, data array and LRU
  modport array (
    input valid, index, way, tag, data
  );

endinterface

/* rtl/icache_tag_array.sv */
/*
 * per-way tag memories plus valid flops, read in the TL stage and written by fills
 * a fill takes the port over a lookup read in the same cycle
 */
`timescale 1ns/10ps

module icache_tag_array #(
  parameter int ways_p = 4,
  parameter int sets_p = 64
) (
  input  logic                                    clk_i,
  input  logic                                    reset_i,
  input  logic                                    rd_v_i,
  input  icache_cfg_pkg::index_t                  rd_index_i,
  output icache_cfg_pkg::ptag_t [ways_p-1:0]      tags_o,
  output icache_cfg_pkg::way_vec_t                valid_o,
  icache_fill_if.array                            fill
);

  icache_cfg_pkg::ptag_t    tag_mem [ways_p][sets_p];
  icache_cfg_pkg::way_vec_t valid_r [sets_p];

  always_ff @(posedge clk_i) begin
    for (int w = 0; w < ways_p; w++) begin
      if (fill.valid) begin
        if (fill.way == icache_cfg_pkg::way_t'(w)) begin
          tag_mem[w][fill.index] <= fill.tag;
        end
      end else if (rd_v_i) begin
        tags_o[w] <= tag_mem[w][rd_index_i];
      end
    end
  end

  // per-set valid flops, all sets empty after reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < sets_p; s++) begin
        valid_r[s] <= '0;
      end
      valid_o <= '0;
    end else if (fill.valid) begin
      valid_r[fill.index][fill.way] <= 1'b1;
    end else if (rd_v_i) begin
      valid_o <= valid_r[rd_index_i];
    end
  end

endmodule

/* rtl/icache_data_array.sv */
/*
 * block storage, one block-wide synchronous memory per way
 * all ways are read together on a lookup and the selected way is written on a fill
 */
`timescale 1ns/10ps

module icache_data_array #(
  parameter int ways_p = 4,
  parameter int sets_p = 64
) (
  input  logic                                 clk_i,
  input  logic                                 rd_v_i,
  input  icache_cfg_pkg::index_t               rd_index_i,
  output icache_cfg_pkg::block_t [ways_p-1:0]  blocks_o,
  icache_fill_if.array                         fill
);

  icache_cfg_pkg::block_t data_mem [ways_p][sets_p];

  // single port per way where a fill write wins over a read
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < ways_p; w++) begin
      if (fill.valid) begin
        if (fill.way == icache_cfg_pkg::way_t'(w)) begin
          data_mem[w][fill.index] <= fill.data;
        end
      end else if (rd_v_i) begin
        blocks_o[w] <= data_mem[w][rd_index_i];
      end
    end
  end

endmodule

/* rtl/icache_lru.sv */
/*
 * tree pseudo-LRU state per set
 * gives the replacement way for the TV index and marks hit or filled ways MRU
 */
`timescale 1ns/10ps

module icache_lru #(
  parameter int ways_p = 4,
  parameter int sets_p = 64
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  icache_cfg_pkg::index_t    index_i,
  input  icache_cfg_pkg::way_vec_t  valid_i,
  input  logic                      hit_v_i,
  input  icache_cfg_pkg::way_t      hit_way_i,
  output icache_cfg_pkg::way_t      victim_o,
  icache_fill_if.array              fill
);

  icache_msg_pkg::lru_bits_t lru_r [sets_p];
  icache_msg_pkg::lru_bits_t cur_bits;
  icache_msg_pkg::lru_bits_t upd_bits;
  icache_cfg_pkg::way_t      lru_way;
  icache_cfg_pkg::way_t      upd_way;
  icache_cfg_pkg::index_t    upd_index;
  logic                      upd_v;

  // follow the tree toward the older side
  assign cur_bits = lru_r[index_i];
  assign lru_way  = cur_bits[0] ? {1'b1, cur_bits[2]} : {1'b0, cur_bits[1]};

  // lowest invalid way beats the tree
  always_comb begin
    victim_o = lru_way;
    for (int w = ways_p - 1; w >= 0; w--) begin
      if (!valid_i[w]) begin
        victim_o = icache_cfg_pkg::way_t'(w);
      end
    end
  end

  // a fill takes priority over a hit update
  assign upd_v     = fill.valid | hit_v_i;
  assign upd_way   = fill.valid ? fill.way : hit_way_i;
  assign upd_index = fill.valid ? fill.index : index_i;

  // point every bit on the used way's path away from it
  always_comb begin
    upd_bits    = lru_r[upd_index];
    upd_bits[0] = ~upd_way[1];
    if (upd_way[1]) begin
      upd_bits[2] = ~upd_way[0];
    end else begin
      upd_bits[1] = ~upd_way[0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < sets_p; s++) begin
        lru_r[s] <= '0;
      end
    end else if (upd_v) begin
      lru_r[upd_index] <= upd_bits;
    end
  end

endmodule

/* rtl/icache_pipe.sv */
/*
 * two-stage lookup pipeline: TL holds the accepted fetch while the arrays are read,
 * the tag compare and word select are registered into TV, which drives the response
 */
`timescale 1ns/10ps

module icache_pipe #(
  parameter int ways_p = 4
) (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  logic                                 fetch_v_i,
  input  icache_cfg_pkg::paddr_t               fetch_addr_i,
  output logic                                 fetch_ready_o,
  output logic                                 rd_v_o,
  output icache_cfg_pkg::index_t               rd_index_o,
  input  icache_cfg_pkg::ptag_t [ways_p-1:0]   tags_i,
  input  icache_cfg_pkg::way_vec_t             valid_i,
  input  icache_cfg_pkg::block_t [ways_p-1:0]  blocks_i,
  output logic                                 data_v_o,
  output icache_cfg_pkg::instr_t               data_o,
  output logic                                 miss_o,
  output icache_cfg_pkg::paddr_t               miss_addr_o,
  output icache_cfg_pkg::index_t               tv_index_o,
  output logic                                 hit_v_o,
  output icache_cfg_pkg::way_t                 hit_way_o,
  output icache_cfg_pkg::way_vec_t             tv_valid_o,
  input  logic                                 stall_i
);

  logic                     v_tl_r;
  icache_cfg_pkg::paddr_t   addr_tl_r;
  logic                     tl_live;
  logic                     hit_tl;
  icache_cfg_pkg::way_t     hit_way_tl;
  icache_cfg_pkg::word_sel_t word_sel_tl;
  icache_cfg_pkg::block_t   hit_block;
  icache_cfg_pkg::instr_t   hit_instr;

  logic                     data_v_r;
  logic                     miss_r;
  icache_cfg_pkg::paddr_t   addr_tv_r;
  icache_cfg_pkg::instr_t   data_r;
  icache_cfg_pkg::way_t     hit_way_r;
  icache_cfg_pkg::way_vec_t valid_tv_r;

  assign fetch_ready_o = ~stall_i;
  assign rd_v_o        = fetch_v_i & ~stall_i;
  assign rd_index_o    = fetch_addr_i[icache_cfg_pkg::index_lsb_c +: icache_cfg_pkg::index_width_c];

  // a miss in TV squashes the younger TL entry
  assign tl_live = v_tl_r & ~miss_r;

  always_comb begin
    hit_tl     = 1'b0;
    hit_way_tl = '0;
    for (int w = 0; w < ways_p; w++) begin
      if (valid_i[w] &&
          tags_i[w] == addr_tl_r[icache_cfg_pkg::tag_lsb_c +: icache_cfg_pkg::tag_width_c]) begin
        hit_tl     = 1'b1;
        hit_way_tl = icache_cfg_pkg::way_t'(w);
      end
    end
  end

  assign word_sel_tl = addr_tl_r[icache_cfg_pkg::word_lsb_c +: icache_cfg_pkg::word_width_c];
  assign hit_block   = blocks_i[hit_way_tl];
  assign hit_instr   = hit_block[{word_sel_tl, 5'd0} +: icache_cfg_pkg::instr_width_c];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_tl_r   <= 1'b0;
      data_v_r <= 1'b0;
      miss_r   <= 1'b0;
    end else begin
      v_tl_r   <= rd_v_o;
      data_v_r <= tl_live & hit_tl;
      miss_r   <= tl_live & ~hit_tl;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_v_o) begin
      addr_tl_r <= fetch_addr_i;
    end
    if (tl_live) begin
      addr_tv_r  <= addr_tl_r;
      data_r     <= hit_instr;
      hit_way_r  <= hit_way_tl;
      valid_tv_r <= valid_i;
    end
  end

  assign data_v_o    = data_v_r;
  assign data_o      = data_r;
  assign miss_o      = miss_r;
  assign miss_addr_o = addr_tv_r;
  assign tv_index_o  = addr_tv_r[icache_cfg_pkg::index_lsb_c +: icache_cfg_pkg::index_width_c];
  assign hit_v_o     = data_v_r;
  assign hit_way_o   = hit_way_r;
  assign tv_valid_o  = valid_tv_r;

endmodule

/* rtl/icache_miss_ctrl.sv */
/*
 * miss tracker that latches the missing address and victim, issues one block request
 * and then accepts the single fill beat and writes it into the arrays
 */
`timescale 1ns/10ps

module icache_miss_ctrl (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    miss_i,
  input  icache_cfg_pkg::paddr_t  miss_addr_i,
  input  icache_cfg_pkg::way_t    victim_i,
  output logic                    stall_o,
  output logic                    miss_req_v_o,
  output icache_cfg_pkg::paddr_t  miss_req_addr_o,
  output icache_cfg_pkg::way_t    miss_req_way_o,
  input  logic                    miss_req_ready_i,
  input  logic                    fill_v_i,
  input  icache_cfg_pkg::block_t  fill_data_i,
  output logic                    fill_ready_o,
  icache_fill_if.miss_ctrl        fill
);

  icache_msg_pkg::miss_state_e state_r;
  icache_cfg_pkg::paddr_t      addr_r;
  icache_cfg_pkg::way_t        way_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= icache_msg_pkg::e_ready;
    end else begin
      case (state_r)
        icache_msg_pkg::e_ready: begin
          if (miss_i) begin
            state_r <= icache_msg_pkg::e_send_req;
          end
        end
        icache_msg_pkg::e_send_req: begin
          if (miss_req_ready_i) begin
            state_r <= icache_msg_pkg::e_wait_fill;
          end
        end
        icache_msg_pkg::e_wait_fill: begin
          if (fill_v_i) begin
            state_r <= icache_msg_pkg::e_ready;
          end
        end
        default: state_r <= icache_msg_pkg::e_ready;
      endcase
    end
  end

  // request fields captured in the miss cycle and held until the fill
  always_ff @(posedge clk_i) begin
    if (state_r == icache_msg_pkg::e_ready && miss_i) begin
      addr_r <= miss_addr_i;
      way_r  <= victim_i;
    end
  end

  // miss_i stalls fetch in the miss cycle itself
  assign stall_o = (state_r != icache_msg_pkg::e_ready) | miss_i;

  assign miss_req_v_o    = (state_r == icache_msg_pkg::e_send_req);
  assign miss_req_addr_o = {addr_r[icache_cfg_pkg::paddr_width_c-1:icache_cfg_pkg::index_lsb_c],
                            {icache_cfg_pkg::index_lsb_c{1'b0}}};
  assign miss_req_way_o  = way_r;
  assign fill_ready_o    = (state_r == icache_msg_pkg::e_wait_fill);

  assign fill.valid = fill_v_i & fill_ready_o;
  assign fill.index = addr_r[icache_cfg_pkg::index_lsb_c +: icache_cfg_pkg::index_width_c];
  assign fill.way   = way_r;
  assign fill.tag   = addr_r[icache_cfg_pkg::tag_lsb_c +: icache_cfg_pkg::tag_width_c];
  assign fill.data  = fill_data_i;

endmodule

/* rtl/icache_top.sv */
/*
 * four-way instruction cache top level
 * fetch, response, miss request and fill are plain valid/ready ports
 */
`timescale 1ns/10ps

module icache_top #(
  parameter int ways_p = icache_cfg_pkg::ways_c,
  parameter int sets_p = icache_cfg_pkg::sets_c
) (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    fetch_v_i,
  input  icache_cfg_pkg::paddr_t  fetch_addr_i,
  output logic                    fetch_ready_o,
  output logic                    data_v_o,
  output icache_cfg_pkg::instr_t  data_o,
  output logic                    miss_req_v_o,
  output icache_cfg_pkg::paddr_t  miss_req_addr_o,
  output icache_cfg_pkg::way_t    miss_req_way_o,
  input  logic                    miss_req_ready_i,
  input  logic                    fill_v_i,
  input  icache_cfg_pkg::block_t  fill_data_i,
  output logic                    fill_ready_o
);

  logic                                 rd_v;
  icache_cfg_pkg::index_t               rd_index;
  icache_cfg_pkg::ptag_t [ways_p-1:0]   tags;
  icache_cfg_pkg::way_vec_t             valid;
  icache_cfg_pkg::block_t [ways_p-1:0]  blocks;
  logic                                 miss;
  icache_cfg_pkg::paddr_t               miss_addr;
  icache_cfg_pkg::index_t               tv_index;
  logic                                 hit_v;
  icache_cfg_pkg::way_t                 hit_way;
  icache_cfg_pkg::way_vec_t             tv_valid;
  icache_cfg_pkg::way_t                 victim;
  logic                                 stall;

  icache_fill_if fill_if_i ();

  icache_pipe #(.ways_p(ways_p)) pipe_i (
    .clk_i, .reset_i, .fetch_v_i, .fetch_addr_i, .fetch_ready_o,
    .rd_v_o(rd_v), .rd_index_o(rd_index),
    .tags_i(tags), .valid_i(valid), .blocks_i(blocks),
    .data_v_o, .data_o,
    .miss_o(miss), .miss_addr_o(miss_addr),
    .tv_index_o(tv_index), .hit_v_o(hit_v), .hit_way_o(hit_way), .tv_valid_o(tv_valid),
    .stall_i(stall)
  );

  icache_tag_array #(.ways_p(ways_p), .sets_p(sets_p)) tag_array_i (
    .clk_i, .reset_i, .rd_v_i(rd_v), .rd_index_i(rd_index),
    .tags_o(tags), .valid_o(valid), .fill(fill_if_i.array)
  );

  icache_data_array #(.ways_p(ways_p), .sets_p(sets_p)) data_array_i (
    .clk_i, .rd_v_i(rd_v), .rd_index_i(rd_index),
    .blocks_o(blocks), .fill(fill_if_i.array)
  );

  icache_lru #(.ways_p(ways_p), .sets_p(sets_p)) lru_i (
    .clk_i, .reset_i, .index_i(tv_index), .valid_i(tv_valid),
    .hit_v_i(hit_v), .hit_way_i(hit_way), .victim_o(victim), .fill(fill_if_i.array)
  );

  icache_miss_ctrl miss_ctrl_i (
    .clk_i, .reset_i, .miss_i(miss), .miss_addr_i(miss_addr), .victim_i(victim),
    .stall_o(stall), .miss_req_v_o, .miss_req_addr_o, .miss_req_way_o, .miss_req_ready_i,
    .fill_v_i, .fill_data_i, .fill_ready_o, .fill(fill_if_i.miss_ctrl)
  );

endmodule

/* verif/icache_properties.sv */
/*
 * concurrent checks on the icache miss handshake and response rules,
 * bound into icache_top
 */
`timescale 1ns/10ps

module icache_properties (
  input logic                        clk_i,
  input logic                        reset_i,
  input logic                        fetch_ready_i,
  input logic                        data_v_i,
  input logic                        miss_req_v_i,
  input icache_cfg_pkg::paddr_t      miss_req_addr_i,
  input icache_cfg_pkg::way_t        miss_req_way_i,
  input logic                        miss_req_ready_i,
  input icache_msg_pkg::miss_state_e state_i
);

  // request holds its fields until accepted
  req_stable_a: assert property (@(posedge clk_i) disable iff (reset_i)
    miss_req_v_i && !miss_req_ready_i |=>
      miss_req_v_i && $stable(miss_req_addr_i) && $stable(miss_req_way_i))
    else $error("miss request changed before it was accepted");

  resp_req_excl_a: assert property (@(posedge clk_i) disable iff (reset_i)
    !(data_v_i && miss_req_v_i))
    else $error("response and miss request valid in the same cycle");

  pending_stall_a: assert property (@(posedge clk_i) disable iff (reset_i)
    state_i != icache_msg_pkg::e_ready |-> !fetch_ready_i)
    else $error("fetch accepted while a miss is pending");

endmodule

bind icache_top icache_properties props_i (
  .clk_i            (clk_i),
  .reset_i          (reset_i),
  .fetch_ready_i    (fetch_ready_o),
  .data_v_i         (data_v_o),
  .miss_req_v_i     (miss_req_v_o),
  .miss_req_addr_i  (miss_req_addr_o),
  .miss_req_way_i   (miss_req_way_o),
  .miss_req_ready_i (miss_req_ready_i),
  .state_i          (miss_ctrl_i.state_r)
);

/* verif/tb_icache.sv */
/*
 * directed testbench for the four-way icache
 * drives fetches on the falling edge and answers block requests from a memory model
 */
`timescale 1ns/10ps

module tb_icache;

  localparam int          reset_cycles_c = 8;
  localparam int          max_hold_c     = 12;
  localparam int          miss_count_c   = 12;
  localparam int          fetch_count_c  = 32;
  localparam int unsigned seed_c         = 32'h8f91_5468;
  // each miss may hold the request and the fill for max_hold_c cycles
  localparam int limit_cycles_c =
    2 * (reset_cycles_c + miss_count_c * (2 * max_hold_c + 16) + fetch_count_c * 4);

  logic                   clk_i;
  logic                   reset_i;
  logic                   fetch_v_i;
  icache_cfg_pkg::paddr_t fetch_addr_i;
  logic                   fetch_ready_o;
  logic                   data_v_o;
  icache_cfg_pkg::instr_t data_o;
  logic                   miss_req_v_o;
  icache_cfg_pkg::paddr_t miss_req_addr_o;
  icache_cfg_pkg::way_t   miss_req_way_o;
  logic                   miss_req_ready_i;
  logic                   fill_v_i;
  icache_cfg_pkg::block_t fill_data_i;
  logic                   fill_ready_o;

  string                  cur_test;
  int                     test_errors;
  int                     error_count;
  int                     tests_run;
  int                     tests_failed;
  icache_cfg_pkg::paddr_t addr_a;

  icache_top icache_top_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // every model word holds its own address xor a constant
  function automatic icache_cfg_pkg::instr_t model_word(icache_cfg_pkg::paddr_t addr);
    return {addr[31:2], 2'b00} ^ 32'h5a5a_0000;
  endfunction

  function automatic icache_cfg_pkg::block_t model_block(icache_cfg_pkg::paddr_t base);
    icache_cfg_pkg::block_t blk;
    for (int i = 0; i < 4; i++) begin
      blk[i*32 +: 32] = model_word(base + 32'(4 * i));
    end
    return blk;
  endfunction

  function automatic icache_cfg_pkg::paddr_t make_addr(icache_cfg_pkg::ptag_t tag,
      icache_cfg_pkg::index_t index, icache_cfg_pkg::word_sel_t word);
    return {tag, index, word, 2'b00};
  endfunction

  task automatic check_instr(string what, icache_cfg_pkg::instr_t exp,
      icache_cfg_pkg::instr_t act);
    if (act !== exp) begin
      $display("FAIL %s: %s expected %h actual %h", cur_test, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_addr(string what, icache_cfg_pkg::paddr_t exp,
      icache_cfg_pkg::paddr_t act);
    if (act !== exp) begin
      $display("FAIL %s: %s expected %h actual %h", cur_test, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_way(string what, icache_cfg_pkg::way_t exp, icache_cfg_pkg::way_t act);
    if (act !== exp) begin
      $display("FAIL %s: %s expected %0d actual %0d", cur_test, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic report_problem(string what);
    $display("ERROR %s: %s", cur_test, what);
    test_errors++;
  endtask

  task automatic begin_test(string name);
    cur_test    = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    tests_run++;
    error_count += test_errors;
    if (test_errors == 0) begin
      $display("test %s passed", cur_test);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", cur_test, test_errors);
    end
  endtask

  // data must show up exactly two edges after acceptance
  task automatic fetch_hit(icache_cfg_pkg::paddr_t addr);
    @(negedge clk_i);
    if (!fetch_ready_o) begin
      report_problem("fetch_ready_o low when a hit was offered");
    end
    fetch_v_i    = 1'b1;
    fetch_addr_i = addr;
    @(negedge clk_i);
    fetch_v_i = 1'b0;
    if (data_v_o) begin
      report_problem("response came one edge after acceptance");
    end
    @(negedge clk_i);
    if (!data_v_o) begin
      report_problem("no response two edges after accepting a hit");
    end else begin
      check_instr("hit data", model_word(addr), data_o);
    end
  endtask

  task automatic fetch_miss(icache_cfg_pkg::paddr_t addr);
    @(negedge clk_i);
    while (!fetch_ready_o) @(negedge clk_i);
    fetch_v_i    = 1'b1;
    fetch_addr_i = addr;
    @(negedge clk_i);
    fetch_v_i = 1'b0;
    @(negedge clk_i);
    if (data_v_o) begin
      report_problem("data returned for a fetch that should miss");
    end
    if (fetch_ready_o) begin
      report_problem("fetch_ready_o still high in the miss cycle");
    end
  endtask

  // answers one block request and holds off both handshakes for hold cycles
  task automatic serve_miss(icache_cfg_pkg::paddr_t addr, icache_cfg_pkg::way_t exp_way,
      int hold);
    icache_cfg_pkg::paddr_t base;
    base = {addr[31:4], 4'h0};
    while (!miss_req_v_o) @(negedge clk_i);
    check_addr("request address", base, miss_req_addr_o);
    check_way("request way", exp_way, miss_req_way_o);
    repeat (hold) begin
      @(negedge clk_i);
      if (!miss_req_v_o) begin
        report_problem("request dropped before it was accepted");
      end
      check_addr("held request address", base, miss_req_addr_o);
      check_way("held request way", exp_way, miss_req_way_o);
      if (fetch_ready_o) begin
        report_problem("fetch_ready_o high while the request is pending");
      end
    end
    miss_req_ready_i = 1'b1;
    @(negedge clk_i);
    miss_req_ready_i = 1'b0;
    repeat (hold) begin
      if (!fill_ready_o || fetch_ready_o) begin
        report_problem("cache not waiting for the fill after the request");
      end
      @(negedge clk_i);
    end
    if (!fill_ready_o) begin
      report_problem("fill_ready_o low when the fill beat was offered");
    end
    fill_v_i    = 1'b1;
    fill_data_i = model_block(base);
    @(negedge clk_i);
    fill_v_i = 1'b0;
    if (!fetch_ready_o) begin
      report_problem("fetch_ready_o did not rise after the fill");
    end
  endtask

  task automatic reset_first_miss();
    begin_test("reset_first_miss");
    if (!fetch_ready_o) begin
      report_problem("fetch_ready_o low after reset");
    end
    if (miss_req_v_o || fill_ready_o || data_v_o) begin
      report_problem("response, request or fill ready active after reset");
    end
    fetch_miss(addr_a);
    serve_miss(addr_a, 2'd0, 0);
    end_test();
  endtask

  task automatic fill_then_hit();
    begin_test("fill_then_hit");
    fetch_hit(addr_a);
    end_test();
  endtask

  task automatic pipelined_hits();
    icache_cfg_pkg::paddr_t addrs [8];
    icache_cfg_pkg::paddr_t base_b;
    begin_test("pipelined_hits");
    base_b = make_addr(22'($urandom()), 6'h05, 2'd0);
    fetch_miss(base_b);
    serve_miss(base_b, 2'd0, 0);
    for (int i = 0; i < 8; i++) begin
      addrs[i] = (i < 4) ? {addr_a[31:4], 4'h0} : base_b;
      addrs[i] = addrs[i] + 32'(4 * (i % 4));
    end
    // one fetch per cycle with responses two cycles behind
    for (int c = 0; c < 10; c++) begin
      @(negedge clk_i);
      if (c >= 2) begin
        if (!data_v_o) begin
          report_problem("missing response in the hit stream");
        end else begin
          check_instr("streamed hit data", model_word(addrs[c-2]), data_o);
        end
      end
      if (c < 8) begin
        if (!fetch_ready_o) begin
          report_problem("fetch_ready_o low during the hit stream");
        end
        fetch_v_i    = 1'b1;
        fetch_addr_i = addrs[c];
      end else begin
        fetch_v_i = 1'b0;
      end
    end
    end_test();
  endtask

  task automatic replacement_order();
    icache_cfg_pkg::ptag_t  tags [5];
    icache_cfg_pkg::index_t set;
    logic [19:0]            r;
    begin_test("replacement");
    set = 6'h2a;
    r   = 20'($urandom());
    for (int k = 0; k < 4; k++) begin
      tags[k] = {r, 2'(k)};
    end
    tags[4] = {~r, 2'b00};
    // empty set fills in way order
    for (int k = 0; k < 4; k++) begin
      fetch_miss(make_addr(tags[k], set, 2'd0));
      serve_miss(make_addr(tags[k], set, 2'd0), icache_cfg_pkg::way_t'(k), 0);
    end
    fetch_hit(make_addr(tags[0], set, 2'd1));
    fetch_hit(make_addr(tags[2], set, 2'd2));
    fetch_hit(make_addr(tags[1], set, 2'd3));
    // MRU order 0, 2, 1 leaves way 3 at the end of the tree
    fetch_miss(make_addr(tags[4], set, 2'd0));
    serve_miss(make_addr(tags[4], set, 2'd0), 2'd3, 0);
    // evicted line misses and the tree now points at way 0
    fetch_miss(make_addr(tags[3], set, 2'd2));
    serve_miss(make_addr(tags[3], set, 2'd2), 2'd0, 0);
    fetch_hit(make_addr(tags[3], set, 2'd2));
    end_test();
  endtask

  task automatic miss_back_pressure();
    icache_cfg_pkg::paddr_t addr;
    int                     hold;
    begin_test("back_pressure");
    for (int n = 0; n < 2; n++) begin
      addr = make_addr(22'($urandom()), 6'h11 + 6'(n), 2'(n + 1));
      hold = 1 + int'($urandom_range(max_hold_c - 1));
      fetch_miss(addr);
      serve_miss(addr, 2'd0, hold);
      fetch_hit(addr);
    end
    end_test();
  endtask

  initial begin
    repeat (limit_cycles_c) @(posedge clk_i);
    $display("ERROR watchdog expired after %0d cycles, the cache stopped responding",
             limit_cycles_c);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    void'($urandom(seed_c));
    error_count      = 0;
    tests_run        = 0;
    tests_failed     = 0;
    addr_a           = 32'h0001_2344;
    fetch_v_i        = 1'b0;
    fetch_addr_i     = '0;
    miss_req_ready_i = 1'b0;
    fill_v_i         = 1'b0;
    fill_data_i      = '0;
    reset_i          = 1'b1;
    repeat (reset_cycles_c) @(negedge clk_i);
    reset_i = 1'b0;
    reset_first_miss();
    fill_then_hit();
    pipelined_hits();
    replacement_order();
    miss_back_pressure();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* all.f */
rtl/icache_cfg_pkg.sv
rtl/icache_msg_pkg.sv
rtl/icache_fill_if.sv
rtl/icache_tag_array.sv
rtl/icache_data_array.sv
rtl/icache_lru.sv
rtl/icache_pipe.sv
rtl/icache_miss_ctrl.sv
rtl/icache_top.sv
verif/icache_properties.sv
verif/tb_icache.sv

/* Makefile */
# Verilator build and run of the icache testbench

VERILATOR ?= verilator
TOP       ?= tb_icache
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
